// File: lsu_access_pkg.sv
/*
  core access types for the load/store unit
  size code 2'b11 is not named and decodes as a byte access
*/
`include "lsu_defs.svh"

package lsu_access_pkg;

  // access size as sent by the execute stage
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } size_e;

  // byte offset of the access inside its word
  typedef logic [`LSU_OFFS_W-1:0] offs_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } state_e;

endpackage

// File: lsu_bus_pkg.sv
/*
  data bus types for the load/store unit
  addresses on the bus are word addresses, the byte offset is dropped
*/
`include "lsu_defs.svh"

package lsu_bus_pkg;

  // one data word as moved on the bus
  typedef logic [`LSU_DATA_W-1:0] word_t;

  // one enable bit per byte lane
  typedef logic [`LSU_BYTES-1:0] be_t;

  // word address without the byte offset bits
  typedef logic [`LSU_DATA_W-`LSU_OFFS_W-1:0] waddr_t;

endpackage

// File: lsu_ctrl.sv
/*
  request controller of the load/store unit, one access outstanding at a time
  misaligned words and half words at offset 3 go out as two bus accesses
  addr_last_o keeps the first failing address of an access
*/
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lsu_req_i,
  input  lsu_access_pkg::size_e   lsu_type_i,
  input  logic [`LSU_DATA_W-1:0]  lsu_addr_i,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  input  logic                    held_we_i,
  output logic                    data_req_o,
  output lsu_bus_pkg::waddr_t     data_addr_o,
  output logic                    second_part_o,
  output logic                    ctrl_capture_o,
  output logic                    first_capture_o,
  output logic                    lsu_req_done_o,
  output logic                    lsu_resp_valid_o,
  output logic                    resp_err_o,
  output logic                    busy_o,
  output logic [`LSU_DATA_W-1:0]  addr_last_o
);

  lsu_access_pkg::state_e state_q, state_d;

  // high between the first grant and the second grant of a split access
  logic split_q, split_d;
  // error seen on the first part
  logic err_q, err_d;

  logic                   split_access;
  logic                   addr_update;
  logic                   addr_second;
  logic [`LSU_DATA_W-1:0] addr_last_q;
  lsu_bus_pkg::waddr_t    waddr_first;
  lsu_bus_pkg::waddr_t    waddr_second;

  // word access off word boundary, or half word in the top lane
  assign split_access =
      ((lsu_type_i == lsu_access_pkg::SIZE_WORD) && (lsu_addr_i[`LSU_OFFS_W-1:0] != '0)) ||
      ((lsu_type_i == lsu_access_pkg::SIZE_HALF) && (lsu_addr_i[`LSU_OFFS_W-1:0] == 2'd3));

  // addr_last_q holds the first part address until the second part is granted
  assign waddr_first  = lsu_addr_i[`LSU_DATA_W-1:`LSU_OFFS_W];
  assign waddr_second = addr_last_q[`LSU_DATA_W-1:`LSU_OFFS_W] + 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    split_d         = split_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_update     = 1'b0;
    addr_second     = 1'b0;
    ctrl_capture_o  = 1'b0;
    first_capture_o = 1'b0;
    lsu_req_done_o  = 1'b0;

    case (state_q)
      lsu_access_pkg::IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_capture_o = 1'b1;
            addr_update    = 1'b1;
            split_d        = split_access;
            lsu_req_done_o = ~split_access;
            state_d = split_access ? lsu_access_pkg::WAIT_RVALID_MIS : lsu_access_pkg::IDLE;
          end else begin
            state_d = split_access ? lsu_access_pkg::WAIT_GNT_MIS : lsu_access_pkg::WAIT_GNT;
          end
        end
      end

      lsu_access_pkg::WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_capture_o = 1'b1;
          addr_update    = 1'b1;
          split_d        = 1'b1;
          state_d        = lsu_access_pkg::WAIT_RVALID_MIS;
        end
      end

      lsu_access_pkg::WAIT_RVALID_MIS: begin
        // second part is on the bus while the first response is pending
        data_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d           = data_err_i;
          first_capture_o = ~held_we_i;
          // a failed first part keeps its own address
          addr_update     = data_gnt_i & ~data_err_i;
          addr_second     = 1'b1;
          split_d         = ~data_gnt_i;
          lsu_req_done_o  = data_gnt_i;
          state_d = data_gnt_i ? lsu_access_pkg::IDLE : lsu_access_pkg::WAIT_GNT;
        end else if (data_gnt_i) begin
          split_d        = 1'b0;
          lsu_req_done_o = 1'b1;
          state_d        = lsu_access_pkg::WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      lsu_access_pkg::WAIT_GNT: begin
        // aligned access or second part of a split one
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_capture_o = 1'b1;
          addr_update    = ~err_q;
          addr_second    = split_q;
          split_d        = 1'b0;
          lsu_req_done_o = 1'b1;
          state_d        = lsu_access_pkg::IDLE;
        end
      end

      lsu_access_pkg::WAIT_RVALID_MIS_GNTS_DONE: begin
        // both grants taken, first response still due
        if (data_rvalid_i) begin
          err_d           = data_err_i;
          first_capture_o = ~held_we_i;
          addr_update     = ~data_err_i;
          addr_second     = 1'b1;
          state_d         = lsu_access_pkg::IDLE;
        end
      end

      default: begin
        state_d = lsu_access_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= lsu_access_pkg::IDLE;
      split_q     <= 1'b0;
      err_q       <= 1'b0;
      addr_last_q <= '0;
    end else begin
      state_q <= state_d;
      split_q <= split_d;
      err_q   <= err_d;
      if (addr_update) begin
        addr_last_q <= addr_second ? {waddr_second, {`LSU_OFFS_W{1'b0}}} : lsu_addr_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign data_addr_o   = split_q ? waddr_second : waddr_first;
  assign second_part_o = split_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (state_q != lsu_access_pkg::IDLE);

  // last response of an access always arrives back in IDLE
  assign lsu_resp_valid_o = data_rvalid_i & (state_q == lsu_access_pkg::IDLE);
  assign resp_err_o       = lsu_resp_valid_o & (err_q | data_err_i);

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {lsu_access_pkg::IDLE, lsu_access_pkg::WAIT_GNT_MIS,
                    lsu_access_pkg::WAIT_RVALID_MIS, lsu_access_pkg::WAIT_GNT,
                    lsu_access_pkg::WAIT_RVALID_MIS_GNTS_DONE});

  a_err_with_rvalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_err_i |-> data_rvalid_i);

endmodule

// File: lsu_defs.svh
/*
  widths shared by the load/store unit and its testbench
  the datapath assumes a 32-bit bus with four byte lanes
*/
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data bus width in bits
`define LSU_DATA_W 32

// byte lanes on the data bus
`define LSU_BYTES 4

// byte offset inside one bus word
`define LSU_OFFS_W 2

// depth of the simulation memory in words
`define LSU_MEM_WORDS 256

`endif

// File: lsu_load_align.sv
/*
  load side realignment and extension
  attributes are captured on the first grant and held until the next access
  result is valid only in the cycle of the final rvalid
*/
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_load_align (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ctrl_capture_i,
  input  logic                  first_capture_i,
  input  lsu_access_pkg::size_e lsu_type_i,
  input  lsu_access_pkg::offs_t offset_i,
  input  logic                  lsu_sign_ext_i,
  input  logic                  lsu_we_i,
  input  lsu_bus_pkg::word_t    data_rdata_i,
  output logic                  held_we_o,
  output lsu_bus_pkg::word_t    lsu_rdata_o
);

  // held request attributes
  lsu_access_pkg::size_e type_q;
  lsu_access_pkg::offs_t offset_q;
  logic                  sign_q;
  logic                  we_q;

  // upper three bytes of the first response of a split load
  logic [`LSU_DATA_W-1:8] rdata_q;

  // per size results before extension
  lsu_bus_pkg::word_t rdata_w;
  logic [15:0]        rdata_h;
  logic [7:0]         rdata_b;
  logic               ext_h;
  logic               ext_b;

  ////////////////////////////////////////////////////////////////////////////
  // held state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      type_q   <= lsu_access_pkg::SIZE_WORD;
      offset_q <= '0;
      sign_q   <= 1'b0;
      we_q     <= 1'b0;
    end else if (ctrl_capture_i) begin
      type_q   <= lsu_type_i;
      offset_q <= offset_i;
      sign_q   <= lsu_sign_ext_i;
      we_q     <= lsu_we_i;
    end
  end

  // byte 0 of the first word is never part of a split result
  always_ff @(posedge clk_i) begin
    if (first_capture_i) begin
      rdata_q <= data_rdata_i[`LSU_DATA_W-1:8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////////////

  // word result
  // low bytes come from the first word, high bytes from the second
  always_comb begin
    case (offset_q)
      2'd1:    rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_w = data_rdata_i;
    endcase
  end

  // half word result, only offset 3 crosses the word boundary
  always_comb begin
    case (offset_q)
      2'd1:    rdata_h = data_rdata_i[23:8];
      2'd2:    rdata_h = data_rdata_i[31:16];
      2'd3:    rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};
      default: rdata_h = data_rdata_i[15:0];
    endcase
  end

  // byte result never crosses
  assign rdata_b = data_rdata_i[{offset_q, 3'b000} +: 8];

  // fill bits for the upper part
  assign ext_h = sign_q & rdata_h[15];
  assign ext_b = sign_q & rdata_b[7];

  always_comb begin
    case (type_q)
      lsu_access_pkg::SIZE_WORD: lsu_rdata_o = rdata_w;
      lsu_access_pkg::SIZE_HALF: lsu_rdata_o = {{16{ext_h}}, rdata_h};
      default:                   lsu_rdata_o = {{24{ext_b}}, rdata_b};
    endcase
  end

  assign held_we_o = we_q;

endmodule

// File: lsu_store_align.sv
/*
  store side lane steering, purely combinational
  inputs must stay stable while the bus request is pending
*/
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_store_align (
  input  lsu_access_pkg::size_e lsu_type_i,
  input  lsu_access_pkg::offs_t offset_i,
  input  logic                  second_part_i,
  input  lsu_bus_pkg::word_t    lsu_wdata_i,
  output lsu_bus_pkg::be_t      data_be_o,
  output lsu_bus_pkg::word_t    data_wdata_o
);

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  // mask of an aligned access of the requested size
  lsu_bus_pkg::be_t base_be;

  // mask shifted across two words
  // low half covers the first part, high half spills into the next word
  logic [2*`LSU_BYTES-1:0] be_span;

  always_comb begin
    case (lsu_type_i)
      lsu_access_pkg::SIZE_WORD: base_be = 4'b1111;
      lsu_access_pkg::SIZE_HALF: base_be = 4'b0011;
      // byte and the unused code
      default:                   base_be = 4'b0001;
    endcase
  end

  // shift by the byte offset inside the word
  assign be_span = {{`LSU_BYTES{1'b0}}, base_be} << offset_i;

  // first part takes the lanes at and above the offset
  // second part takes whatever spilled over the word boundary
  assign data_be_o = second_part_i ? be_span[2*`LSU_BYTES-1:`LSU_BYTES]
                                   : be_span[`LSU_BYTES-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////////////////////

  // doubled word so a left shift wraps the top bytes back to lane 0
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;

  // rotate left by offset bytes
  // byte 0 of the store lands in the lane of the start address
  assign wdata_dbl = {lsu_wdata_i, lsu_wdata_i} << {offset_i, 3'b000};

  // upper word of the shifted pair is the rotated data
  // both parts of a split store use this same word, only the mask differs
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

// File: lsu_top.sv
/*
  load/store unit top, core side and req/gnt/rvalid bus side
  core holds request inputs until lsu_req_done_o and waits for the response
*/
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // core side
  input  logic                    lsu_req_i,
  input  logic                    lsu_we_i,
  input  logic [1:0]              lsu_type_i,
  input  logic                    lsu_sign_ext_i,
  input  logic [`LSU_DATA_W-1:0]  lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0]  lsu_wdata_i,
  output logic                    lsu_req_done_o,
  output logic                    lsu_resp_valid_o,
  output logic                    lsu_rdata_valid_o,
  output logic [`LSU_DATA_W-1:0]  lsu_rdata_o,
  output logic                    load_err_o,
  output logic                    store_err_o,
  output logic                    busy_o,
  output logic [`LSU_DATA_W-1:0]  addr_last_o,
  // data bus
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  output logic [`LSU_DATA_W-1:0]  data_addr_o,
  output logic                    data_we_o,
  output logic [`LSU_BYTES-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0]  data_wdata_o,
  input  logic [`LSU_DATA_W-1:0]  data_rdata_i
);

  lsu_access_pkg::size_e lsu_type;
  lsu_access_pkg::offs_t offset;
  lsu_bus_pkg::waddr_t   data_waddr;
  logic                  second_part;
  logic                  ctrl_capture;
  logic                  first_capture;
  logic                  resp_err;
  logic                  held_we;

  // code 2'b11 passes through and decodes as byte
  assign lsu_type = lsu_access_pkg::size_e'(lsu_type_i);
  assign offset   = lsu_addr_i[`LSU_OFFS_W-1:0];

  lsu_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lsu_req_i        (lsu_req_i),
    .lsu_type_i       (lsu_type),
    .lsu_addr_i       (lsu_addr_i),
    .data_gnt_i       (data_gnt_i),
    .data_rvalid_i    (data_rvalid_i),
    .data_err_i       (data_err_i),
    .held_we_i        (held_we),
    .data_req_o       (data_req_o),
    .data_addr_o      (data_waddr),
    .second_part_o    (second_part),
    .ctrl_capture_o   (ctrl_capture),
    .first_capture_o  (first_capture),
    .lsu_req_done_o   (lsu_req_done_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .resp_err_o       (resp_err),
    .busy_o           (busy_o),
    .addr_last_o      (addr_last_o)
  );

  lsu_store_align u_store_align (
    .lsu_type_i    (lsu_type),
    .offset_i      (offset),
    .second_part_i (second_part),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ctrl_capture_i  (ctrl_capture),
    .first_capture_i (first_capture),
    .lsu_type_i      (lsu_type),
    .offset_i        (offset),
    .lsu_sign_ext_i  (lsu_sign_ext_i),
    .lsu_we_i        (lsu_we_i),
    .data_rdata_i    (data_rdata_i),
    .held_we_o       (held_we),
    .lsu_rdata_o     (lsu_rdata_o)
  );

  // bus address is always word aligned
  assign data_addr_o = {data_waddr, {`LSU_OFFS_W{1'b0}}};
  assign data_we_o   = lsu_we_i;

  // error routing follows the held direction of the access
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~held_we;
  assign load_err_o        = resp_err & ~held_we;
  assign store_err_o       = resp_err & held_we;

  // controller never requests a part that the aligner leaves without lanes
  a_be_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_be_o != '0));

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f sim.f -o tb_lsu_sim
./obj_dir/tb_lsu_sim 2>&1 | tee sim.log
# a missing pass line gives a failing status
grep -q "^TEST PASS$" sim.log
echo "simulation passed"

// File: sim.f
+incdir+.
lsu_bus_pkg.sv
lsu_access_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

// File: tb_lsu.sv
/*
  testbench for the load/store unit, directed tests against a byte reference
  the reference copies the memory model contents once reset is released
  test addresses stay inside the model memory, so no access wraps around
*/
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu;

  localparam int unsigned SEED = 32'h794c_c113;
  localparam int BYTES_TOTAL = 4 * `LSU_MEM_WORDS;
  localparam int WORD_RUNS = 8;
  // aligned pairs, sub-word loads, misaligned stores, error paths
  localparam int N_ACCESSES = 2 * WORD_RUNS + 18 + 17 + 4;
  localparam int CYCLES_PER_ACCESS = 20;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   lsu_req;
  logic                   lsu_we;
  logic [1:0]             lsu_type;
  logic                   lsu_sign_ext;
  logic [`LSU_DATA_W-1:0] lsu_addr;
  logic [`LSU_DATA_W-1:0] lsu_wdata;
  logic                   lsu_req_done;
  logic                   lsu_resp_valid;
  logic                   lsu_rdata_valid;
  logic [`LSU_DATA_W-1:0] lsu_rdata;
  logic                   load_err;
  logic                   store_err;
  logic                   busy;
  logic [`LSU_DATA_W-1:0] addr_last;
  logic                   data_req;
  logic                   data_gnt;
  logic                   data_rvalid;
  logic                   data_err;
  logic                   data_we;
  logic [`LSU_DATA_W-1:0] data_addr;
  logic [`LSU_DATA_W-1:0] data_wdata;
  logic [`LSU_DATA_W-1:0] data_rdata;
  logic [`LSU_BYTES-1:0]  data_be;
  logic                   err_arm;
  int                     err_nth;

  // byte image of the memory
  logic [7:0] ref_mem [0:BYTES_TOTAL-1];
  integer     seed;

  // core view of the last response
  logic [31:0] rsp_rdata;
  logic        rsp_rdata_valid;
  logic        rsp_load_err;
  logic        rsp_store_err;

  lsu_top UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .lsu_req_i (lsu_req), .lsu_we_i (lsu_we), .lsu_type_i (lsu_type),
    .lsu_sign_ext_i (lsu_sign_ext), .lsu_addr_i (lsu_addr), .lsu_wdata_i (lsu_wdata),
    .lsu_req_done_o (lsu_req_done), .lsu_resp_valid_o (lsu_resp_valid),
    .lsu_rdata_valid_o (lsu_rdata_valid), .lsu_rdata_o (lsu_rdata),
    .load_err_o (load_err), .store_err_o (store_err), .busy_o (busy),
    .addr_last_o (addr_last), .data_req_o (data_req), .data_gnt_i (data_gnt),
    .data_rvalid_i (data_rvalid), .data_err_i (data_err), .data_addr_o (data_addr),
    .data_we_o (data_we), .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_rdata_i (data_rdata)
  );

  tb_lsu_mem #(.SEED (SEED)) u_mem (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (data_req), .addr_i (data_addr),
    .we_i (data_we), .be_i (data_be), .wdata_i (data_wdata), .err_arm_i (err_arm),
    .err_nth_i (err_nth), .gnt_o (data_gnt), .rvalid_o (data_rvalid), .err_o (data_err),
    .rdata_o (data_rdata)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // bound of 20 cycles per access, plus reset and error arming
  initial begin
    repeat ((N_ACCESSES + 4) * CYCLES_PER_ACCESS) @(posedge clk_i);
    $display("watchdog expired before all accesses completed");
    $display("TEST FAIL");
    $fatal(1, "simulation hung");
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, want);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic int size_bytes(input logic [1:0] size);
    case (size)
      2'b00:   return 4;
      2'b01:   return 2;
      default: return 1;
    endcase
  endfunction

  // two bus parts when the bytes run past the end of the word
  function automatic int part_count(input logic [1:0] size, input logic [31:0] addr);
    return (int'(addr[1:0]) + size_bytes(size) > 4) ? 2 : 1;
  endfunction

  function automatic int byte_index(input logic [31:0] addr, input int b);
    return int'((addr + 32'(b)) % BYTES_TOTAL);
  endfunction

  // little endian gather, then fill with the top bit when signed
  function automatic logic [31:0] expected_load(input logic [1:0] size, input logic sign,
                                                input logic [31:0] addr);
    logic [31:0] v;
    int          n;
    n = size_bytes(size);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[8*b +: 8] = ref_mem[byte_index(addr, b)];
    end
    if (sign && v[8*n-1]) begin
      for (int b = n; b < 4; b++) begin
        v[8*b +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_word_addr();
    logic [31:0] idx;
    // last word left out so base + 4 still exists
    idx = $unsigned($random(seed)) % (`LSU_MEM_WORDS - 1);
    return idx << 2;
  endfunction

  task automatic copy_memory();
    for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
      for (int b = 0; b < 4; b++) begin
        ref_mem[4*w + b] = u_mem.mem[w][8*b +: 8];
      end
    end
  endtask

  task automatic arm_error(input int nth);
    @(negedge clk_i);
    err_arm = 1'b1;
    err_nth = nth;
    @(negedge clk_i);
    err_arm = 1'b0;
  endtask

  // one access from request to response, counting grants on the way
  task automatic run_access(input logic we, input logic [1:0] size, input logic sign,
                            input logic [31:0] addr, input logic [31:0] wdata);
    int   gnts;
    logic done;
    logic granted;
    gnts    = 0;
    done    = 1'b0;
    granted = 1'b0;
    @(negedge clk_i);
    lsu_req      = 1'b1;
    lsu_we       = we;
    lsu_type     = size;
    lsu_sign_ext = sign;
    lsu_addr     = addr;
    lsu_wdata    = wdata;
    while (!done) begin
      @(posedge clk_i);
      granted = data_req && data_gnt;
      if (granted) gnts++;
      done = lsu_req_done;
    end
    // done marks the cycle of the last grant
    expect_equal("lsu_req_done_o with data_gnt_i", granted, 1'b1);
    expect_equal("data_gnt_i count at lsu_req_done_o", gnts, part_count(size, addr));
    @(negedge clk_i);
    lsu_req = 1'b0;
    do begin
      @(posedge clk_i);
      if (data_req && data_gnt) gnts++;
    end while (!lsu_resp_valid);
    rsp_rdata       = lsu_rdata;
    rsp_rdata_valid = lsu_rdata_valid;
    rsp_load_err    = load_err;
    rsp_store_err   = store_err;
    expect_equal("data_gnt_i count", gnts, part_count(size, addr));
    // single response cycle
    @(posedge clk_i);
    expect_equal("lsu_resp_valid_o", lsu_resp_valid, 1'b0);
  endtask

  task automatic write_access(input logic [1:0] size, input logic [31:0] addr,
                              input logic [31:0] wdata);
    run_access(1'b1, size, 1'b0, addr, wdata);
    expect_equal("store_err_o", rsp_store_err, 1'b0);
    expect_equal("lsu_rdata_valid_o", rsp_rdata_valid, 1'b0);
    for (int b = 0; b < size_bytes(size); b++) begin
      ref_mem[byte_index(addr, b)] = wdata[8*b +: 8];
    end
  endtask

  task automatic read_access(input logic [1:0] size, input logic sign, input logic [31:0] addr);
    logic [31:0] want;
    want = expected_load(size, sign, addr);
    run_access(1'b0, size, sign, addr, '0);
    expect_equal("lsu_rdata_valid_o", rsp_rdata_valid, 1'b1);
    expect_equal("load_err_o", rsp_load_err, 1'b0);
    expect_equal("lsu_rdata_o", rsp_rdata, want);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    @(posedge clk_i);
    expect_equal("busy_o", busy, 1'b0);
    expect_equal("data_req_o", data_req, 1'b0);
    expect_equal("lsu_req_done_o", lsu_req_done, 1'b0);
    expect_equal("lsu_resp_valid_o", lsu_resp_valid, 1'b0);
    expect_equal("lsu_rdata_valid_o", lsu_rdata_valid, 1'b0);
    expect_equal("load_err_o", load_err, 1'b0);
    expect_equal("store_err_o", store_err, 1'b0);
    expect_equal("addr_last_o", addr_last, 32'h0);
  endtask

  task automatic aligned_words();
    logic [31:0] addr;
    logic [31:0] data;
    for (int i = 0; i < WORD_RUNS; i++) begin
      addr = rand_word_addr();
      data = $random(seed);
      write_access(2'b00, addr, data);
      read_access(2'b00, 1'b0, addr);
      expect_equal("addr_last_o", addr_last, addr);
    end
  endtask

  task automatic sub_word_loads();
    logic [31:0] base;
    base = rand_word_addr();
    // top bits set in some lanes and clear in others
    write_access(2'b00, base, 32'h80ff_7f01);
    write_access(2'b00, base + 4, 32'h7e01_fe80);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        read_access(2'b10, s[0], base + off);
        read_access(2'b01, s[0], base + off);
      end
    end
  endtask

  task automatic misaligned_stores();
    logic [31:0] base;
    logic [31:0] data;
    for (int off = 1; off < 4; off++) begin
      base = rand_word_addr();
      data = $random(seed);
      write_access(2'b00, base + off, data);
      // both words whole, so untouched neighbors are seen too
      read_access(2'b00, 1'b0, base);
      read_access(2'b00, 1'b0, base + 4);
      read_access(2'b00, 1'b0, base + off);
      read_access(2'b10, 1'b1, base + off + 4);
    end
    base = rand_word_addr();
    write_access(2'b01, base + 3, 32'h0000_a55a);
    read_access(2'b01, 1'b1, base + 3);
  endtask

  task automatic error_paths();
    logic [31:0] base;
    base = rand_word_addr();
    // failing first part keeps its own address
    arm_error(1);
    run_access(1'b0, 2'b00, 1'b0, base + 1, '0);
    expect_equal("load_err_o", rsp_load_err, 1'b1);
    expect_equal("lsu_rdata_valid_o", rsp_rdata_valid, 1'b0);
    expect_equal("store_err_o", rsp_store_err, 1'b0);
    expect_equal("addr_last_o", addr_last, base + 1);
    arm_error(2);
    run_access(1'b0, 2'b00, 1'b0, base + 2, '0);
    expect_equal("load_err_o", rsp_load_err, 1'b1);
    expect_equal("lsu_rdata_valid_o", rsp_rdata_valid, 1'b0);
    // second word is the first to fail here
    expect_equal("addr_last_o", addr_last, base + 4);
    // failed store is dropped by the memory
    arm_error(1);
    run_access(1'b1, 2'b00, 1'b0, base, 32'h1234_5678);
    expect_equal("store_err_o", rsp_store_err, 1'b1);
    expect_equal("load_err_o", rsp_load_err, 1'b0);
    read_access(2'b00, 1'b0, base);
  endtask

  initial begin
    seed         = SEED;
    rst_ni       = 1'b0;
    lsu_req      = 1'b0;
    lsu_we       = 1'b0;
    lsu_type     = 2'b00;
    lsu_sign_ext = 1'b0;
    lsu_addr     = '0;
    lsu_wdata    = '0;
    err_arm      = 1'b0;
    err_nth      = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    copy_memory();
    idle_after_reset();
    aligned_words();
    sub_word_loads();
    misaligned_stores();
    error_paths();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: tb_lsu_mem.sv
/*
  data bus memory model for the load/store unit testbench
  grants after 0 to 3 cycles of request, answers 1 to 3 cycles after grant, in order
  err_arm_i loads err_nth_i, the Nth access granted from then on fails and is not written
*/
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu_mem #(
  parameter int unsigned SEED = 32'h794c_c113
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  logic                   we_i,
  input  logic [`LSU_BYTES-1:0]  be_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic                   err_arm_i,
  input  int                     err_nth_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic                   err_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  localparam int AW = $clog2(`LSU_MEM_WORDS);

  logic [`LSU_DATA_W-1:0] mem [0:`LSU_MEM_WORDS-1];

  // pending responses, oldest first
  logic [`LSU_DATA_W-1:0] rsp_data [$];
  logic                   rsp_err [$];
  int                     rsp_due [$];

  integer        seed;
  int            cyc;
  int            gnt_cnt;
  int            due;
  int            last_due;
  int            err_left;
  logic          fail;
  logic [AW-1:0] idx;

  initial begin
    seed     = SEED;
    cyc      = 0;
    gnt_cnt  = 0;
    last_due = 0;
    err_left = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    err_o    = 1'b0;
    rdata_o  = '0;
    // odd multiplier keeps every word distinct
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      mem[i] = 32'(i) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
    end
    forever begin
      // sample the bus as it stood during the cycle that just ended
      @(posedge clk_i);
      cyc = cyc + 1;
      if (!rst_ni) begin
        rsp_data.delete();
        rsp_err.delete();
        rsp_due.delete();
        gnt_cnt  = 0;
        last_due = 0;
        err_left = 0;
      end else begin
        if (err_arm_i) begin
          err_left = err_nth_i;
        end
        if (req_i && gnt_o) begin
          idx  = addr_i[`LSU_OFFS_W +: AW];
          fail = (err_left == 1);
          if (err_left != 0) begin
            err_left = err_left - 1;
          end
          for (int b = 0; b < `LSU_BYTES; b++) begin
            if (we_i && !fail && be_i[b]) begin
              mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          // due is the cycle index that carries rvalid, never two in one cycle
          due = cyc + int'($unsigned($random(seed)) % 3);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rsp_data.push_back(fail ? 32'hdead_beef : mem[idx]);
          rsp_err.push_back(fail);
          rsp_due.push_back(due);
          gnt_cnt = int'($unsigned($random(seed)) % 4);
        end else if (req_i && gnt_cnt != 0) begin
          gnt_cnt = gnt_cnt - 1;
        end
      end
      // drive the next cycle
      @(negedge clk_i);
      gnt_o = rst_ni && (gnt_cnt == 0);
      if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
        rvalid_o = 1'b1;
        err_o    = rsp_err.pop_front();
        rdata_o  = rsp_data.pop_front();
        due      = rsp_due.pop_front();
      end else begin
        rvalid_o = 1'b0;
        err_o    = 1'b0;
      end
    end
  end

endmodule
